/* common/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_SETS       64
`define ICACHE_LINE_WORDS 4

// bus widths
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32

// fixed fields of the refill burst
`define ICACHE_AXI_LEN        3   // four beats
`define ICACHE_AXI_SIZE       2   // 4 bytes per beat
`define ICACHE_AXI_BURST_INCR 1
`define ICACHE_AXI_ID         0

`endif

/* common/icache_pkg.sv */
`include "icache_cfg.svh"

package icache_pkg;

    // address fields from msb down are tag then index then word then byte
    localparam int BYTE_W    = $clog2(`ICACHE_DATA_W / 8);
    localparam int OFFSET_W  = $clog2(`ICACHE_LINE_WORDS);
    localparam int INDEX_W   = $clog2(`ICACHE_SETS);
    localparam int TAG_W     = `ICACHE_ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
    localparam int INDEX_LSB = BYTE_W + OFFSET_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [`ICACHE_DATA_W-1:0] word_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [OFFSET_W-1:0]       offset_t;

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        addr_t addr;    // fetch address echoed back
        word_t inst;
    } fetch_rsp_t;

    typedef struct packed {
        logic [3:0] id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0] id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } refill_state_e;

endpackage

/* icache/beat_counter.sv */
`timescale 1ns/10ps

module beat_counter (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                burst_start_i,   // fsm is about to enter ADDR
    input  logic                beat_i,          // accepted read beat
    output icache_pkg::offset_t beat_idx_o
);

    import icache_pkg::*;

    offset_t cnt_q;

    // wraps back to zero after the fourth beat
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (burst_start_i) begin
            cnt_q <= '0;
        end else if (beat_i) begin
            cnt_q <= offset_t'(cnt_q + 1'b1);
        end
    end

    assign beat_idx_o = cnt_q;   // word slot for the beat on the bus now

endmodule

/* icache/line_store.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module line_store (
    input  logic                clk,
    input  logic                rst_n_i,
    // read port, one cycle latency
    input  icache_pkg::index_t  rd_index_i,
    input  icache_pkg::offset_t rd_offset_i,
    output icache_pkg::tag_t    rd_tag_o,
    output logic                rd_valid_o,
    output icache_pkg::word_t   rd_word_o,
    // refill write port
    input  logic                wr_en_i,
    input  icache_pkg::index_t  wr_index_i,
    input  icache_pkg::offset_t wr_offset_i,
    input  icache_pkg::word_t   wr_word_i,
    input  logic                wr_tag_en_i,
    input  icache_pkg::tag_t    wr_tag_i
);

    import icache_pkg::*;

    localparam int WORDS = `ICACHE_SETS * `ICACHE_LINE_WORDS;

    logic [`ICACHE_SETS-1:0] valid_q;
    tag_t                    tag_mem  [`ICACHE_SETS];
    word_t                   data_mem [WORDS];   // word address is {index, offset}

    // valid bits and the registered valid read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (wr_tag_en_i) begin
                valid_q[wr_index_i] <= 1'b1;   // line complete
            end
            rd_valid_o <= valid_q[rd_index_i];
        end
    end

    // one word per refill beat
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            data_mem[{wr_index_i, wr_offset_i}] <= wr_word_i;
        end
        if (wr_tag_en_i) begin
            tag_mem[wr_index_i] <= wr_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_o  <= tag_mem[rd_index_i];
        rd_word_o <= data_mem[{rd_index_i, rd_offset_i}];
    end

endmodule

/* icache/refill_fsm.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module refill_fsm (
    input  logic                clk,
    input  logic                rst_n_i,
    // miss from the lookup stage
    input  logic                miss_valid_i,
    input  icache_pkg::addr_t   miss_addr_i,
    // axi read address
    output logic                ar_valid_o,
    input  logic                ar_ready_i,
    output icache_pkg::axi_ar_t ar_o,
    // axi read data
    input  logic                r_valid_i,
    output logic                r_ready_o,
    input  icache_pkg::axi_r_t  r_i,
    // store write port
    output logic                wr_en_o,
    output icache_pkg::index_t  wr_index_o,
    output logic                wr_tag_en_o,
    output icache_pkg::tag_t    wr_tag_o,
    output icache_pkg::word_t   wr_word_o,
    // beat counter control
    output logic                burst_start_o,
    output logic                beat_o,
    output logic                fill_done_o
);

    import icache_pkg::*;

    refill_state_e state_q;
    refill_state_e state_d;
    addr_t         line_q;   // line aligned miss address
    logic          start;
    logic          beat;

    assign start = (state_q == IDLE) & miss_valid_i;
    assign beat  = r_valid_i & r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (miss_valid_i) begin
                    state_d = ADDR;
                end
            end
            ADDR: begin
                if (ar_ready_i) begin
                    state_d = DATA;
                end
            end
            DATA: begin
                if (beat && r_i.last) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;   // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            line_q <= {miss_addr_i[`ICACHE_ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
        end
    end

    // burst fields stay fixed while ar_valid_o is up
    always_comb begin
        ar_o.id    = 4'(`ICACHE_AXI_ID);
        ar_o.addr  = line_q;
        ar_o.len   = 8'(`ICACHE_AXI_LEN);
        ar_o.size  = 3'(`ICACHE_AXI_SIZE);
        ar_o.burst = 2'(`ICACHE_AXI_BURST_INCR);
    end

    assign ar_valid_o = (state_q == ADDR);
    assign r_ready_o  = (state_q == DATA);

    // rresp is not checked
    assign wr_en_o     = beat;
    assign wr_word_o   = r_i.data;
    assign wr_tag_en_o = beat & r_i.last;   // tag and valid go in with the last word
    assign wr_index_o  = line_q[INDEX_LSB +: INDEX_W];
    assign wr_tag_o    = line_q[TAG_LSB +: TAG_W];

    assign burst_start_o = start;
    assign beat_o        = beat;
    assign fill_done_o   = (state_q == DONE);

endmodule

/* icache/lookup_stage.sv */
`timescale 1ns/10ps

module lookup_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // fetch request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  icache_pkg::fetch_req_t req_i,
    // fetch response
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output icache_pkg::fetch_rsp_t rsp_o,
    // store read port
    output icache_pkg::index_t     rd_index_o,
    output icache_pkg::offset_t    rd_offset_o,
    input  icache_pkg::tag_t       rd_tag_i,
    input  logic                   rd_hit_valid_i,
    input  icache_pkg::word_t      rd_word_i,
    // refill handoff
    output logic                   miss_valid_o,
    output icache_pkg::addr_t      miss_addr_o,
    input  logic                   fill_done_i
);

    import icache_pkg::*;

    logic       busy_q;     // a request sits in the stage
    logic       wait_q;     // its line is being refilled
    logic       kill_q;     // flushed while the refill runs
    addr_t      addr_q;
    logic       rsp_valid_q;
    fetch_rsp_t rsp_q;

    logic       lookup;
    logic       hit;
    logic       slot_free;
    logic       hit_done;
    logic       req_fire;
    addr_t      rd_addr;

    // store output belongs to addr_q whenever no refill is pending
    assign lookup    = busy_q & ~wait_q;
    assign hit       = rd_hit_valid_i && (rd_tag_i == addr_q[TAG_LSB +: TAG_W]);
    assign slot_free = ~rsp_valid_q | rsp_ready_i;
    assign hit_done  = lookup & hit & (slot_free | flush_i);

    assign req_ready_o = (~busy_q | hit_done) & slot_free;
    assign req_fire    = req_valid_i & req_ready_o;

    // new request goes to the store at once, else keep re-reading the held one
    assign rd_addr     = req_fire ? req_i.addr : addr_q;
    assign rd_index_o  = rd_addr[INDEX_LSB +: INDEX_W];
    assign rd_offset_o = rd_addr[BYTE_W +: OFFSET_W];

    assign miss_valid_o = (lookup & ~hit) | wait_q;   // held until fill_done
    assign miss_addr_o  = addr_q;

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            wait_q <= 1'b0;
            kill_q <= 1'b0;
        end else begin
            if (req_fire) begin
                busy_q <= 1'b1;
            end else if (hit_done || (fill_done_i && (kill_q || flush_i))) begin
                busy_q <= 1'b0;   // flushed fill ends without a re-read
            end

            if (fill_done_i) begin
                wait_q <= 1'b0;
                kill_q <= 1'b0;
            end else if (miss_valid_o) begin
                wait_q <= 1'b1;
                kill_q <= kill_q | flush_i;
            end
        end
    end

    // response slot
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (flush_i) begin
            rsp_valid_q <= 1'b0;
        end else if (hit_done) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= req_i.addr;
        end
        if (hit_done) begin
            rsp_q.addr <= addr_q;
            rsp_q.inst <= rd_word_i;
        end
    end

endmodule

/* icache/icache_top.sv */
`timescale 1ns/10ps

module icache_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // fetch side
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  icache_pkg::fetch_req_t req_i,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output icache_pkg::fetch_rsp_t rsp_o,
    // axi read channels
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    output icache_pkg::axi_ar_t    ar_o,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    input  icache_pkg::axi_r_t     r_i
);

    import icache_pkg::*;

    // store read port
    index_t  rd_index;
    offset_t rd_offset;
    tag_t    rd_tag;
    logic    rd_valid;
    word_t   rd_word;

    // miss handoff
    logic    miss_valid;
    addr_t   miss_addr;
    logic    fill_done;

    // refill write port
    logic    wr_en;
    index_t  wr_index;
    logic    wr_tag_en;
    tag_t    wr_tag;
    word_t   wr_word;
    logic    burst_start;
    logic    beat;
    offset_t beat_idx;

    lookup_stage lookup_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .flush_i(flush_i),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .req_i(req_i),
        .rsp_valid_o(rsp_valid_o),
        .rsp_ready_i(rsp_ready_i),
        .rsp_o(rsp_o),
        .rd_index_o(rd_index),
        .rd_offset_o(rd_offset),
        .rd_tag_i(rd_tag),
        .rd_hit_valid_i(rd_valid),
        .rd_word_i(rd_word),
        .miss_valid_o(miss_valid),
        .miss_addr_o(miss_addr),
        .fill_done_i(fill_done)
    );

    line_store store_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rd_index_i(rd_index),
        .rd_offset_i(rd_offset),
        .rd_tag_o(rd_tag),
        .rd_valid_o(rd_valid),
        .rd_word_o(rd_word),
        .wr_en_i(wr_en),
        .wr_index_i(wr_index),
        .wr_offset_i(beat_idx),    // word slot comes from the beat count
        .wr_word_i(wr_word),
        .wr_tag_en_i(wr_tag_en),
        .wr_tag_i(wr_tag)
    );

    refill_fsm refill_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .miss_valid_i(miss_valid),
        .miss_addr_i(miss_addr),
        .ar_valid_o(ar_valid_o),
        .ar_ready_i(ar_ready_i),
        .ar_o(ar_o),
        .r_valid_i(r_valid_i),
        .r_ready_o(r_ready_o),
        .r_i(r_i),
        .wr_en_o(wr_en),
        .wr_index_o(wr_index),
        .wr_tag_en_o(wr_tag_en),
        .wr_tag_o(wr_tag),
        .wr_word_o(wr_word),
        .burst_start_o(burst_start),
        .beat_o(beat),
        .fill_done_o(fill_done)
    );

    beat_counter beat_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .burst_start_i(burst_start),
        .beat_i(beat),
        .beat_idx_o(beat_idx)
    );

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                ar_valid_i,
    output logic                ar_ready_o,
    input  icache_pkg::axi_ar_t ar_i,
    output logic                r_valid_o,
    input  logic                r_ready_i,
    output icache_pkg::axi_r_t  r_o
);

    import icache_pkg::*;

    localparam word_t MEM_KEY = 32'hc3a5_0f96;   // word at A is A xor key

    int    seed = 32'h664c_26f3;
    logic  ar_fire;
    logic  r_fire;
    addr_t ar_addr;
    logic  busy;
    int    beat;

    // handshakes as seen on the rising edge
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ar_fire <= 1'b0;
            r_fire  <= 1'b0;
        end else begin
            ar_fire <= ar_valid_i & ar_ready_o;
            r_fire  <= r_valid_o & r_ready_i;
            if (ar_valid_i && ar_ready_o) begin
                ar_addr <= ar_i.addr;
            end
        end
    end

    // outputs only move on the falling edge
    initial begin
        busy       = 1'b0;
        beat       = 0;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;   // id and resp stay zero
        forever begin
            @(negedge clk);
            if (!rst_n_i) begin
                busy       = 1'b0;
                ar_ready_o = 1'b0;
                r_valid_o  = 1'b0;
            end else begin
                if (ar_fire) begin
                    busy = 1'b1;
                    beat = 0;
                end
                if (r_fire) begin
                    r_valid_o = 1'b0;
                    beat      = beat + 1;
                    busy      = (beat < 4);
                end
                ar_ready_o = !busy && (($random(seed) & 3) != 0);
                // random gap before the next beat
                if (busy && !r_valid_o && (($random(seed) & 1) != 0)) begin
                    r_valid_o = 1'b1;
                    r_o.data  = (ar_addr + addr_t'(4 * beat)) ^ MEM_KEY;
                    r_o.last  = (beat == 3);
                end
            end
        end
    end

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;

    import icache_pkg::*;

    localparam word_t MEM_KEY = 32'hc3a5_0f96;

    logic       clk;
    logic       rst_n_i;
    logic       flush_i;
    logic       req_valid_i;
    logic       req_ready_o;
    fetch_req_t req_i;
    logic       rsp_valid_o;
    logic       rsp_ready_i;
    fetch_rsp_t rsp_o;
    logic       ar_valid_o;
    logic       ar_ready_i;
    axi_ar_t    ar_o;
    logic       r_valid_i;
    logic       r_ready_o;
    axi_r_t     r_i;

    byte   case_op   [$];
    addr_t case_addr [$];
    int    case_ars  [$];   // expected AR count per case

    int         seed = 32'h664c_26f3;
    int         cycle_limit = 0;
    addr_t      cur_addr = '0;
    logic       cur_expect = 1'b0;   // flushed requests get no response
    // written by the monitor only
    int         cycles = 0;
    int         acc_count = 0;
    int         acc_cycle = 0;
    int         ready_cycle = 0;
    int         rsp_count = 0;
    int         rsp_cycle = 0;
    int         ar_count = 0;
    logic       rsp_taken = 1'b0;
    logic       rsp_held = 1'b0;
    logic       in_burst = 1'b0;   // between AR accept and the rlast beat
    fetch_rsp_t rsp_prev = '0;

    icache_top UUT (.*);

    axi_mem_model mem_inst (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .ar_valid_i(ar_valid_o),
        .ar_ready_o(ar_ready_i),
        .ar_i(ar_o),
        .r_valid_o(r_valid_i),
        .r_ready_i(r_ready_o),
        .r_o(r_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t mem_word(input addr_t a);
        return {a[31:2], 2'b00} ^ MEM_KEY;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string what);
        abort_run($sformatf("Error at %0t ns: %s", $time, what));
    endtask

    // sample on the rising edge, the main process reads results at the falling edge
    always @(posedge clk) begin
        if (rst_n_i) begin
            cycles = cycles + 1;
            assert (cycles <= cycle_limit)
                else abort_run($sformatf("run timed out after %0d cycles", cycles));
            assert (r_ready_o == in_burst)
                else value_error($sformatf("r_ready_o is %b, want %b", r_ready_o, in_burst));
            if (ar_valid_o && ar_ready_i) begin
                ar_count = ar_count + 1;
                assert (ar_o.len == 8'd3 && ar_o.size == 3'd2 && ar_o.burst == 2'd1
                        && ar_o.id == 4'd0 && ar_o.addr[3:0] == 4'h0)
                    else value_error($sformatf("bad AR fields %h", ar_o));
                in_burst = 1'b1;
            end
            if (r_valid_i && r_ready_o && r_i.last) begin
                in_burst = 1'b0;
            end
            if (rsp_held) begin
                assert (rsp_valid_o && rsp_o == rsp_prev)
                    else value_error("response dropped or changed while held");
            end
            if (rsp_valid_o && rsp_ready_i) begin
                assert (cur_expect && !rsp_taken)
                    else value_error($sformatf("extra response for %h", rsp_o.addr));
                assert (rsp_o.addr == cur_addr)
                    else value_error($sformatf("addr %h, want %h", rsp_o.addr, cur_addr));
                assert (rsp_o.inst == mem_word(cur_addr))
                    else value_error($sformatf("inst %h, want %h", rsp_o.inst,
                                               mem_word(cur_addr)));
                rsp_taken = 1'b1;
                rsp_count = rsp_count + 1;
                rsp_cycle = cycles;
            end
            if (req_valid_i && req_ready_o) begin
                acc_count = acc_count + 1;
                acc_cycle = cycles;
                rsp_taken = 1'b0;
            end
            if (req_ready_o) begin
                ready_cycle = cycles;
            end
            rsp_held = rsp_valid_o && !rsp_ready_i && !flush_i;
            rsp_prev = rsp_o;
        end
    end

    initial begin
        int    fd;
        int    cnt;
        string line;
        byte   op;
        addr_t addr;
        int    n;
        int    ar_before;
        int    acc_before;
        int    rsp_before;

        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b1;

        fd = $fopen("bench/icache_cases.txt", "r");
        assert (fd != 0) else abort_run("could not open bench/icache_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt != 0 && line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%c %h %d", op, addr, n);
                assert (cnt == 3) else abort_run($sformatf("cannot parse case line: %s", line));
                case_op.push_back(op);
                case_addr.push_back(addr);
                case_ars.push_back(n);
            end
        end
        $fclose(fd);
        cycle_limit = 64 * case_op.size();

        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        assert (req_ready_o && !rsp_valid_o && !ar_valid_o && !r_ready_o)
            else value_error("handshake outputs not idle after reset");

        foreach (case_op[i]) begin
            ar_before   = ar_count;
            acc_before  = acc_count;
            rsp_before  = rsp_count;
            cur_addr    = case_addr[i];
            cur_expect  = (case_op[i] != "F");
            req_i.addr  = case_addr[i];
            req_valid_i = 1'b1;
            while (acc_count == acc_before) @(negedge clk);
            req_valid_i = 1'b0;
            flush_i     = (case_op[i] == "F");   // high on the edge after acceptance
            rsp_ready_i = (case_op[i] != "B");
            @(negedge clk);
            flush_i = 1'b0;

            if (cur_expect) begin
                while (rsp_count == rsp_before) begin
                    @(negedge clk);
                    if (case_op[i] == "B") begin
                        rsp_ready_i = (($random(seed) & 3) == 0);
                    end
                end
                rsp_ready_i = 1'b1;
                if (case_op[i] == "R" && case_ars[i] == 0) begin
                    assert (rsp_cycle == acc_cycle + 2)
                        else value_error($sformatf("hit took %0d cycles", rsp_cycle - acc_cycle));
                end
            end else begin
                while (ready_cycle <= acc_cycle) @(negedge clk);   // refill drained
                assert (!rsp_valid_o && rsp_count == rsp_before)
                    else value_error($sformatf("response after flush of %h", cur_addr));
            end
            assert (ar_count - ar_before == case_ars[i])
                else value_error($sformatf("case %0d at %h made %0d ARs, want %0d",
                                           i, cur_addr, ar_count - ar_before, case_ars[i]));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* bench/icache_cases.txt */
# op addr expected_ars
# op is R read, F read then flush, B read with response back-pressure
R 00001000 1
R 00001004 0
R 0000100c 0
B 00001008 0
R 00002010 1
B 00002014 0
F 00003020 1
R 00003020 0
R 00003024 0
F 00001000 0
R 00001000 0
R 00000100 1
R 00001100 1
R 00000104 1
R 00001108 1
B 00004040 1
B 00004044 0
R 0000411c 1
R 00000100 1
R 80000ff0 1
R 80000ffc 0

/* src.f */
+incdir+common
common/icache_pkg.sv
icache/beat_counter.sv
icache/line_store.sv
icache/refill_fsm.sv
icache/lookup_stage.sv
icache/icache_top.sv
bench/axi_mem_model.sv
bench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root, exit status follows the testbench
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/10ps \
        -f src.f --top-module icache_tb -o icache_sim \
    && ./obj_dir/icache_sim || exit 1
